/* flist.f */
src/vicPkg.sv
src/mibShifter.sv
src/pixelDelay.sv
src/colorSelect.sv
src/vicVideoOut.sv
sim/clkGen.sv
sim/vicChecker.sv
sim/vicOut_asserts.sv
sim/vicTb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module vicTb -o vicSim \
	&& ./obj_dir/vicSim | tee /dev/stderr | grep -q "NO ERRORS" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* sim/clkGen.sv */
// Testbench clock, one-in-four pixel enable and power-on reset generator
`timescale 1ns/1ps
`default_nettype none

module clkGen (
	output logic clk33,
	output logic clken8,
	output logic arstN
);

	// Position inside the four-cycle pixel period
	logic [1:0] phase = 2'd0;

	initial begin
		clk33  = 1'b0;
		clken8 = 1'b0;
		arstN  = 1'b0;
	end

	// 40 ns period
	always #20 clk33 = ~clk33;

	// The enable is registered so it changes just after the edge, like a real divider
	always @(posedge clk33) begin
		phase  <= phase + 2'd1;
		clken8 <= (phase == 2'd3);
	end

	// Reset held for ten clocks, released off the edge
	initial begin
		repeat (10) @(posedge clk33);
		#2 arstN = 1'b1;
	end

endmodule

`default_nettype wire

/* sim/vicChecker.sv */
// Scoreboard that lines up expected pixel colors with the DUT output and reports per test
`timescale 1ns/1ps
`default_nettype none

module vicChecker (
	input  logic          clk33,
	input  logic          clken8,
	input  vicPkg::colorT color
);

	// Enable edges seen so far, used to time each comparison
	int enCount = 0;
	int errors  = 0;
	int checks  = 0;
	int tests   = 0;
	int testErr = 0;

	// Pending expectations, one entry per driven pixel
	string         qName [$];
	int            qOff  [$];
	int            qTag  [$];
	vicPkg::colorT qExp  [$];
	bit            qLast [$];

	// Inputs driven now are sampled on the next enable and show up at the output
	// three enables after that, so the color is read four enables from now
	task automatic post(string name, int off, vicPkg::colorT exp, bit last);
		qName.push_back(name);
		qOff.push_back(off);
		qTag.push_back(enCount + 4);
		qExp.push_back(exp);
		qLast.push_back(last);
	endtask

	function automatic int pending();
		return qTag.size();
	endfunction

	// Color is read before this edge updates it
	always @(posedge clk33) begin
		string         name;
		int            off;
		vicPkg::colorT exp;
		bit            last;
		if (clken8) begin
			enCount++;
			while (qTag.size() > 0 && qTag[0] == enCount) begin
				name = qName.pop_front();
				off  = qOff.pop_front();
				exp  = qExp.pop_front();
				last = qLast.pop_front();
				void'(qTag.pop_front());
				checks++;
				if (color !== exp) begin
					errors++;
					testErr++;
					$display("FAILED %s offset %0d: expected %h, actual %h",
						name, off, exp, color);
				end
				if (last) begin
					tests++;
					if (testErr == 0)
						$display("PASS %s", name);
					else
						$display("FAIL %s with %0d mismatching pixels", name, testErr);
					testErr = 0;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* sim/vicOut_asserts.sv */
// Concurrent checks on the color select output stage, bound into colorSelect
`timescale 1ns/1ps
`default_nettype none

module vicOut_asserts (
	input logic          clk33,
	input logic          arstN,
	input logic          clken8,
	input logic          blank,
	input vicPkg::colorT color
);

	// Blank taken on one enable reaches the output register two enables later
	// Enables are four clocks apart so that is eight clocks after the sample
	blankBlack: assert property (@(posedge clk33) disable iff (!arstN)
		clken8 && $past(clken8 && blank, 8) |=> color == '0)
		else $error("color not black two enables after blank was sampled");

	// The output register only moves on the pixel enable
	holdBetween: assert property (@(posedge clk33) disable iff (!arstN)
		!clken8 |=> $stable(color))
		else $error("color changed without clken8");

	// Reset forces black
	resetBlack: assert property (@(posedge clk33)
		!arstN |-> color == '0)
		else $error("color not black during reset");

endmodule

bind colorSelect vicOut_asserts asserts_i (
	.clk33  (clk33),
	.arstN  (arstN),
	.clken8 (clken8),
	.blank  (blank),
	.color  (color)
);

`default_nettype wire

/* sim/vicTb.sv */
// Testbench top with stimulus table, pixel loop, reference color rules, LCG and watchdog
`timescale 1ns/1ps
`default_nettype none

module vicTb;

	// One stimulus table row where a check offset of 8'hFF selects no hand-worked value
	typedef struct packed {
		vicPkg::modeT      mode;
		vicPkg::colorRegsT regs;
		vicPkg::mibRegT    spr0;
		vicPkg::mibRegT    spr1;
		logic [23:0]       data0;
		logic [23:0]       data1;
		logic [8:0]        start;
		logic [7:0]        count;
		logic [31:0]       fgBits;
		logic [7:0]        borderFrom;
		logic [7:0]        borderTo;
		logic [7:0]        blankFrom;
		logic [7:0]        blankTo;
		logic [7:0]        chkOff;
		vicPkg::colorT     chkColor;
	} testT;

	localparam int numTests = 6;

	logic clk33;
	logic clken8;
	logic arstN;
	logic                     mibWrite;
	logic [2:0]               mibIndex;
	vicPkg::mibRegT           mibRegs;
	logic [23:0]              mibData;
	vicPkg::colorRegsT        colorRegs;
	vicPkg::modeT             mode;
	vicPkg::bgPixelT          bgPixel;
	logic [8:0]               rasterX;
	logic                     blank;
	logic                     border;
	vicPkg::colorT            color;

	testT        stimTable [numTests];
	string       names [numTests];
	int unsigned lcgState = 26139;

	clkGen clk_i (.clk33(clk33), .clken8(clken8), .arstN(arstN));

	vicVideoOut dut_i (
		.clk33 (clk33), .arstN (arstN), .clken8 (clken8),
		.mibWrite (mibWrite), .mibIndex (mibIndex), .mibRegs (mibRegs),
		.mibData (mibData), .colorRegs (colorRegs), .mode (mode),
		.bgPixel (bgPixel), .rasterX (rasterX), .blank (blank),
		.border (border), .color (color)
	);

	vicChecker chk_i (.clk33(clk33), .clken8(clken8), .color(color));

	function automatic int unsigned lcgNext();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState >> 16;
	endfunction

	function automatic vicPkg::mibRegT mkSprite(int x, int col, bit multi, bit behind);
		vicPkg::mibRegT r;
		r.xPos     = 9'(x);
		r.color    = 4'(col);
		r.multi    = multi;
		r.behindBg = behind;
		r.enable   = 1'b1;
		return r;
	endfunction

	// Expected color worked out from the color rules with sprite 0 applied last
	function automatic vicPkg::colorT expectColor(testT t, int p, vicPkg::colorT bg, bit fg);
		vicPkg::colorT  c;
		vicPkg::mibRegT r;
		logic [23:0]    d;
		logic [1:0]     code;
		int             k;
		c = (t.mode inside {3'b101, 3'b110, 3'b111}) ? 4'h0 : bg;
		for (int s = 1; s >= 0; s--) begin
			r = (s == 1) ? t.spr1 : t.spr0;
			d = (s == 1) ? t.data1 : t.data0;
			k = int'(t.start) + p - int'(r.xPos);
			if (r.enable && k >= 0 && k < 24 && (!r.behindBg || !fg)) begin
				if (r.multi) begin
					code = d[23 - 2 * (k / 2) -: 2];
					if (code == 2'b01)
						c = t.regs.mm0;
					else if (code == 2'b10)
						c = r.color;
					else if (code == 2'b11)
						c = t.regs.mm1;
				end else if (d[23 - k]) begin
					c = r.color;
				end
			end
		end
		if (p >= int'(t.blankFrom) && p <= int'(t.blankTo))
			c = 4'h0;
		else if (p >= int'(t.borderFrom) && p <= int'(t.borderTo))
			c = t.regs.ec;
		return c;
	endfunction

	task automatic waitEnable();
		do @(posedge clk33); while (!clken8);
	endtask

	task automatic writeSprite(int idx, vicPkg::mibRegT r, logic [23:0] d);
		@(posedge clk33);
		#2;
		mibWrite = 1'b1;
		mibIndex = 3'(idx);
		mibRegs  = r;
		mibData  = d;
		@(posedge clk33);
		#2 mibWrite = 1'b0;
	endtask

	// ======================================================================
	// Stimulus
	// ======================================================================

	initial begin
		testT          t;
		vicPkg::colorT bg;
		vicPkg::colorT exp;
		bit            fg;
		names[0] = "bgPass";
		stimTable[0] = '{3'b000, 12'hABE, '0, '0, 24'h0, 24'h0, 9'd10, 8'd16, 32'h0,
			8'hFF, 8'h0, 8'hFF, 8'h0, 8'hFF, 4'h0};
		names[1] = "illegalMode";
		stimTable[1] = '{3'b101, 12'hABE, mkSprite(20, 7, 0, 0), '0, 24'hF00000, 24'h0,
			9'd16, 8'd32, 32'h0, 8'hFF, 8'h0, 8'hFF, 8'h0, 8'd5, 4'h7};
		names[2] = "stdSprite";
		stimTable[2] = '{3'b000, 12'hABE, mkSprite(40, 3, 0, 0), '0, 24'hA5C3F0, 24'h0,
			9'd36, 8'd32, 32'h0, 8'hFF, 8'h0, 8'hFF, 8'h0, 8'd4, 4'h3};
		names[3] = "multiSprite";
		stimTable[3] = '{3'b001, 12'hABE, mkSprite(60, 5, 1, 0), '0, 24'h1B1B00, 24'h0,
			9'd58, 8'd30, 32'h0, 8'hFF, 8'h0, 8'hFF, 8'h0, 8'd4, 4'hA};
		names[4] = "priority";
		stimTable[4] = '{3'b000, 12'hABE, mkSprite(100, 2, 0, 1), mkSprite(104, 9, 0, 0),
			24'hFFFFFF, 24'hFFFFFF, 9'd98, 8'd32, 32'hFF00FF00,
			8'hFF, 8'h0, 8'hFF, 8'h0, 8'd6, 4'h2};
		names[5] = "borderBlank";
		stimTable[5] = '{3'b111, 12'hABE, mkSprite(140, 6, 0, 0), '0, 24'hFFFFFF, 24'h0,
			9'd136, 8'd24, 32'h0, 8'd2, 8'd12, 8'd8, 8'd16, 8'd4, 4'hE};

		mibWrite  = 1'b0;
		mibIndex  = '0;
		mibRegs   = '0;
		mibData   = '0;
		colorRegs = '0;
		mode      = '0;
		bgPixel   = '0;
		rasterX   = '0;
		blank     = 1'b0;
		border    = 1'b0;

		@(posedge arstN);
		for (int n = 0; n < numTests; n++) begin
			t = stimTable[n];
			// Let the previous test leave the pipeline before settings change
			waitEnable();
			#2;
			rasterX = '0;
			blank   = 1'b0;
			border  = 1'b0;
			repeat (4) waitEnable();
			writeSprite(0, t.spr0, t.data0);
			writeSprite(1, t.spr1, t.data1);
			mode      = t.mode;
			colorRegs = t.regs;
			for (int p = 0; p < int'(t.count); p++) begin
				bg = 4'(lcgNext());
				fg = t.fgBits[p % 32];
				waitEnable();
				#2;
				rasterX         = t.start + 9'(p);
				bgPixel.color   = bg;
				bgPixel.fgFlag  = fg;
				blank           = (p >= int'(t.blankFrom) && p <= int'(t.blankTo));
				border          = (p >= int'(t.borderFrom) && p <= int'(t.borderTo));
				// Hand-worked values from the table take the place of the model
				if (p == int'(t.chkOff))
					exp = t.chkColor;
				else
					exp = expectColor(t, p, bg, fg);
				chk_i.post(names[n], p, exp, p == int'(t.count) - 1);
			end
		end

		waitEnable();
		#2 rasterX = '0;
		while (chk_i.pending() > 0)
			waitEnable();
		$display("Tests %0d, checks %0d, errors %0d", chk_i.tests, chk_i.checks, chk_i.errors);
		if (chk_i.errors == 0 && chk_i.tests == numTests) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	// Watchdog sized from the table since each pixel takes four clocks of 40 ns
	initial begin
		longint limit;
		#1;
		limit = 0;
		for (int n = 0; n < numTests; n++)
			limit += (longint'(stimTable[n].count) + 8) * 160;
		limit += 20000;
		#(limit);
		$display("Timeout: simulation did not finish within %0d ns", limit);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* src/colorSelect.sv */
// Final color resolution with mode check, sprite priority, border and blank
`timescale 1ns/1ps
`default_nettype none

module colorSelect (
	input  logic                clk33,
	input  logic                arstN,
	input  logic                clken8,
	input  vicPkg::modeT        mode,
	input  vicPkg::bgPixelT     bgPixel,
	input  vicPkg::mibCodeT     mibCode,
	input  vicPkg::mibRegT      mibSettings [vicPkg::mibCount],
	input  vicPkg::colorRegsT   colorRegs,
	input  logic                blank,
	input  logic                border,
	output vicPkg::colorT       color
);

	vicPkg::colorT                  nextCode;
	vicPkg::colorT                  codeReg;
	logic [vicPkg::sideDelay-1:0]   blankPipe;
	logic [vicPkg::sideDelay-1:0]   borderPipe;

	// ======================================================================
	// Code stage
	// ======================================================================

	always_comb begin
		// Illegal ecm/bmm/mcm combinations show black in place of the background
		case (mode)
			3'b101, 3'b110, 3'b111: nextCode = '0;
			default:                nextCode = bgPixel.color;
		endcase
		// Walk from the top sprite down so the lowest numbered sprite is applied last
		for (int n = vicPkg::mibCount - 1; n >= 0; n--) begin
			// A behind-background sprite only shows over non-foreground pixels
			if (!mibSettings[n].behindBg || !bgPixel.fgFlag) begin
				if (mibSettings[n].multi) begin
					case (mibCode[n])
						2'b01:   nextCode = colorRegs.mm0;
						2'b10:   nextCode = mibSettings[n].color;
						2'b11:   nextCode = colorRegs.mm1;
						default: nextCode = nextCode;
					endcase
				end else if (mibCode[n][1]) begin
					nextCode = mibSettings[n].color;
				end
			end
		end
	end

	always_ff @(posedge clk33 or negedge arstN) begin
		if (!arstN) begin
			codeReg <= '0;
		end else if (clken8) begin
			codeReg <= nextCode;
		end
	end

	// ======================================================================
	// Side signals and output stage
	// ======================================================================

	// Blank and border wait here until the matching pixel reaches the output
	always_ff @(posedge clk33 or negedge arstN) begin
		if (!arstN) begin
			blankPipe  <= '0;
			borderPipe <= '0;
		end else if (clken8) begin
			blankPipe  <= {blankPipe[vicPkg::sideDelay-2:0], blank};
			borderPipe <= {borderPipe[vicPkg::sideDelay-2:0], border};
		end
	end

	// Blanking beats the border, which beats any pixel data
	always_ff @(posedge clk33 or negedge arstN) begin
		if (!arstN) begin
			color <= '0;
		end else if (clken8) begin
			if (blankPipe[vicPkg::sideDelay-1])
				color <= '0;
			else if (borderPipe[vicPkg::sideDelay-1])
				color <= colorRegs.ec;
			else
				color <= codeReg;
		end
	end

endmodule

`default_nettype wire

/* src/mibShifter.sv */
// Sprite register sets and serializers producing one 2-bit code per sprite per pixel
`timescale 1ns/1ps
`default_nettype none

module mibShifter (
	input  logic                         clk33,
	input  logic                         arstN,
	input  logic                         clken8,
	input  logic                         mibWrite,
	input  logic [vicPkg::mibIdxW-1:0]   mibIndex,
	input  vicPkg::mibRegT               mibRegs,
	input  logic [vicPkg::mibBits-1:0]   mibData,
	input  logic [vicPkg::xPosW-1:0]     rasterX,
	output vicPkg::mibRegT               mibSettings [vicPkg::mibCount],
	output vicPkg::mibCodeT              mibCode
);

	// Per-sprite state arrays indexed by sprite number
	vicPkg::mibRegT               settings [vicPkg::mibCount];
	logic [vicPkg::mibBits-1:0]   shiftReg [vicPkg::mibCount];
	logic [vicPkg::pixCntW-1:0]   pixCnt   [vicPkg::mibCount];
	logic                         active   [vicPkg::mibCount];
	// Set while a multicolor pair is on its first of two pixels
	logic                         holdPair [vicPkg::mibCount];
	logic [1:0]                   codeReg  [vicPkg::mibCount];

	for (genvar i = 0; i < vicPkg::mibCount; i++) begin : gMib
		localparam logic [vicPkg::mibIdxW-1:0] thisIdx = i;

		// Register set written by the strobe when this sprite is selected
		always_ff @(posedge clk33 or negedge arstN) begin
			if (!arstN) begin
				settings[i] <= '0;
			end else if (mibWrite && mibIndex == thisIdx) begin
				settings[i] <= mibRegs;
			end
		end

		// Sprite line data shifts out from the top bits downward
		always_ff @(posedge clk33) begin
			if (mibWrite && mibIndex == thisIdx) begin
				shiftReg[i] <= mibData;
			end else if (clken8) begin
				if (settings[i].multi) begin
					// Advance to the next pair only after the second pixel of a pair
					if ((active[i] && holdPair[i]) && pixCnt[i] != vicPkg::mibLastPix)
						shiftReg[i] <= {shiftReg[i][vicPkg::mibBits-3:0], 2'b00};
				end else if (active[i] && pixCnt[i] != vicPkg::mibLastPix) begin
					shiftReg[i] <= {shiftReg[i][vicPkg::mibBits-2:0], 1'b0};
				end else if (!active[i] && settings[i].enable
						&& rasterX == settings[i].xPos) begin
					shiftReg[i] <= {shiftReg[i][vicPkg::mibBits-2:0], 1'b0};
				end
			end
		end

		// Line sequencer armed by the X match and done after mibBits pixels
		always_ff @(posedge clk33 or negedge arstN) begin
			if (!arstN) begin
				active[i]   <= 1'b0;
				holdPair[i] <= 1'b0;
				pixCnt[i]   <= '0;
				codeReg[i]  <= 2'b00;
			end else if (mibWrite && mibIndex == thisIdx) begin
				// New line data restarts the sprite from idle
				active[i]   <= 1'b0;
				holdPair[i] <= 1'b0;
				pixCnt[i]   <= '0;
				codeReg[i]  <= 2'b00;
			end else if (clken8) begin
				if (!active[i]) begin
					if (settings[i].enable && rasterX == settings[i].xPos) begin
						active[i] <= 1'b1;
						pixCnt[i] <= 1;
						if (settings[i].multi) begin
							codeReg[i]  <= shiftReg[i][vicPkg::mibBits-1 -: 2];
							holdPair[i] <= 1'b1;
						end else begin
							codeReg[i] <= {shiftReg[i][vicPkg::mibBits-1], 1'b0};
						end
					end
				end else if (pixCnt[i] == vicPkg::mibLastPix) begin
					// Whole line is out so the sprite goes quiet until the next match
					active[i]   <= 1'b0;
					holdPair[i] <= 1'b0;
					codeReg[i]  <= 2'b00;
				end else begin
					pixCnt[i] <= pixCnt[i] + 1'b1;
					if (settings[i].multi) begin
						// Second pixel of a pair repeats the code already shown
						if (!holdPair[i])
							codeReg[i] <= shiftReg[i][vicPkg::mibBits-1 -: 2];
						holdPair[i] <= !holdPair[i];
					end else begin
						codeReg[i] <= {shiftReg[i][vicPkg::mibBits-1], 1'b0};
					end
				end
			end
		end

		assign mibCode[i]     = codeReg[i];
		assign mibSettings[i] = settings[i];
	end

endmodule

`default_nettype wire

/* src/pixelDelay.sv */
// Enable-stepped delay line for an arbitrary packed payload type
`timescale 1ns/1ps
`default_nettype none

module pixelDelay #(
	parameter type payloadT = logic
) (
	input  logic    clk33,
	input  logic    arstN,
	input  logic    clken8,
	input  payloadT din,
	output payloadT dout
);

	// One entry per pixel enable of delay
	payloadT stage [vicPkg::bgDelay];

	// The chain only moves on the pixel enable, so it counts pixels and not clocks
	always_ff @(posedge clk33 or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < vicPkg::bgDelay; i++)
				stage[i] <= '0;
		end else if (clken8) begin
			stage[0] <= din;
			for (int i = 1; i < vicPkg::bgDelay; i++)
				stage[i] <= stage[i-1];
		end
	end

	// Oldest entry is the delayed payload
	assign dout = stage[vicPkg::bgDelay-1];

endmodule

`default_nettype wire

/* src/vicPkg.sv */
// Shared sprite count, pipeline constants and struct types for the video back end
`default_nettype none

package vicPkg;

	// ======================================================================
	// Sizes and pipeline constants
	// ======================================================================

	// Number of movable object blocks (sprites)
	localparam int mibCount = 8;

	// Width of the sprite index used when writing sprite registers
	localparam int mibIdxW = $clog2(mibCount);

	// Pixel data bits in one sprite line
	localparam int mibBits = 24;

	// Counter wide enough to count every pixel of a sprite line
	localparam int pixCntW = $clog2(mibBits + 1);

	// Count value reached once the last sprite pixel has been emitted
	localparam logic [pixCntW-1:0] mibLastPix = pixCntW'(mibBits);

	// Width of the horizontal raster position and of a sprite X position
	localparam int xPosW = 9;

	// Background delay in pixel enables, matching the shifter's output register
	localparam int bgDelay = 1;

	// Enable stages that blank and border travel through inside the color select
	localparam int sideDelay = 2;

	// ======================================================================
	// Shared types
	// ======================================================================

	// A 4-bit palette color code
	typedef logic [3:0] colorT;

	// Display mode bits, ecm is the most significant
	typedef struct packed {
		logic ecm;
		logic bmm;
		logic mcm;
	} modeT;

	// One background pixel as delivered by the character or bitmap logic
	typedef struct packed {
		colorT color;
		// Set when the pixel is foreground data rather than background
		logic  fgFlag;
	} bgPixelT;

	// Per-sprite register set
	typedef struct packed {
		logic [xPosW-1:0] xPos;
		colorT            color;
		logic             multi;
		// Data priority, the sprite goes behind foreground pixels when set
		logic             behindBg;
		logic             enable;
	} mibRegT;

	// Color registers shared by every sprite and the border
	typedef struct packed {
		colorT mm0;
		colorT mm1;
		colorT ec;
	} colorRegsT;

	// One 2-bit pixel code per sprite
	typedef logic [mibCount-1:0][1:0] mibCodeT;

endpackage

`default_nettype wire

/* src/vicVideoOut.sv */
// Top level of the pixel back end joining shifter, background delay and color select
`timescale 1ns/1ps
`default_nettype none

module vicVideoOut (
	input  logic                         clk33,
	input  logic                         arstN,
	input  logic                         clken8,
	input  logic                         mibWrite,
	input  logic [vicPkg::mibIdxW-1:0]   mibIndex,
	input  vicPkg::mibRegT               mibRegs,
	input  logic [vicPkg::mibBits-1:0]   mibData,
	input  vicPkg::colorRegsT            colorRegs,
	input  vicPkg::modeT                 mode,
	input  vicPkg::bgPixelT              bgPixel,
	input  logic [vicPkg::xPosW-1:0]     rasterX,
	input  logic                         blank,
	input  logic                         border,
	output vicPkg::colorT                color
);

	// Sprite codes and the stored register sets feeding the priority logic
	vicPkg::mibCodeT   mibCode;
	vicPkg::mibRegT    mibSettings [vicPkg::mibCount];
	// Background pixel lined up with the registered sprite codes
	vicPkg::bgPixelT   bgAligned;

	mibShifter shifter_i (
		.clk33       (clk33),
		.arstN       (arstN),
		.clken8      (clken8),
		.mibWrite    (mibWrite),
		.mibIndex    (mibIndex),
		.mibRegs     (mibRegs),
		.mibData     (mibData),
		.rasterX     (rasterX),
		.mibSettings (mibSettings),
		.mibCode     (mibCode)
	);

	pixelDelay #(
		.payloadT (vicPkg::bgPixelT)
	) delay_i (
		.clk33  (clk33),
		.arstN  (arstN),
		.clken8 (clken8),
		.din    (bgPixel),
		.dout   (bgAligned)
	);

	// Blank and border enter undelayed, the select stage lines them up itself
	colorSelect select_i (
		.clk33       (clk33),
		.arstN       (arstN),
		.clken8      (clken8),
		.mode        (mode),
		.bgPixel     (bgAligned),
		.mibCode     (mibCode),
		.mibSettings (mibSettings),
		.colorRegs   (colorRegs),
		.blank       (blank),
		.border      (border),
		.color       (color)
	);

endmodule

`default_nettype wire
